/* list.f */
+incdir+common
common/dqla_pkg.sv
design/reg_write_decode.sv
motor_bank/motor_channel_bank.sv
dac/dac_serializer.sv
design/reg_read_mux.sv
design/dqla_top.sv
tb/tb_dqla.sv

/* run.sh */
#!/bin/sh
# Build and run the DQLA motor-command testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_dqla -o tb_dqla

out=$(./obj_dir/tb_dqla)
echo "$out"

if echo "$out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

/* tb/tb_dqla.sv */
`timescale 1ns/1ps

module tb_dqla;

    // ------------------------------------------------------------------------
    // Register map and DAC frame values
    // ------------------------------------------------------------------------
    localparam logic [3:0] OPC_WRITE_UPDATE = 4'b0011;   // DAC write and update
    localparam logic [3:0] OFF_BOARD        = 4'd0;
    localparam logic [3:0] OFF_CMD          = 4'd1;
    localparam logic [3:0] OFF_STATUS       = 4'd12;
    localparam int         BUSY_LIMIT       = 20;    // Cycles until busy moves
    localparam int         XFER_LIMIT       = 400;   // Four frames fit easily

    logic        sysclk;
    logic        rst_n;
    logic [15:0] reg_raddr;
    logic [15:0] reg_waddr;
    logic [31:0] reg_wdata;
    logic        reg_wen;
    logic        blk_wen;
    logic        wdog_timeout;
    logic [31:0] reg_rdata;
    logic        wdog_clear;
    logic        dac_sclk;
    logic [1:0]  dac_mosi;
    logic [1:0]  dac_csn;

    logic [15:0] model_cmd [8];        // Reference copy of each command
    logic [15:0] exp_snap [8];         // Commands a transfer should carry
    logic [23:0] cap_frame [2][4];     // Captured frames per chain
    int          cap_count;
    logic        wen_clear;            // wdog_clear seen during last write
    string       cur_test;
    int          test_errs;
    int          total_errs;
    int          tests_run;
    int          tests_failed;
    int unsigned seed_val;

    dqla_top uut (
        .sysclk(sysclk), .rst_n(rst_n), .reg_raddr(reg_raddr), .reg_waddr(reg_waddr),
        .reg_wdata(reg_wdata), .reg_wen(reg_wen), .blk_wen(blk_wen),
        .wdog_timeout(wdog_timeout), .reg_rdata(reg_rdata), .wdog_clear(wdog_clear),
        .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csn(dac_csn)
    );

    initial begin
        sysclk = 1'b0;
        forever #50 sysclk = ~sysclk;   // 100 ns period
    end

    // Main space, channel field, offset field
    function automatic logic [15:0] reg_addr(input int ch, input logic [3:0] off);
        return {4'h0, 4'h0, ch[3:0], off};
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        total_errs += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, test_errs);
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus access
    // ------------------------------------------------------------------------
    task automatic write_reg(input logic [15:0] addr, input logic [31:0] data,
                             input logic blk);
        @(posedge sysclk);
        reg_waddr <= addr;
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        blk_wen   <= blk;
        @(negedge sysclk);
        wen_clear = wdog_clear;   // Combinational so only valid in strobe cycle
        @(posedge sysclk);        // Write lands here
        reg_wen <= 1'b0;
        blk_wen <= 1'b0;
    endtask

    task automatic write_cmd(input int ch, input logic [31:0] data, input logic blk);
        write_reg(reg_addr(ch, OFF_CMD), data, blk);
        model_cmd[ch-1] = data[15:0];   // Only low half is kept
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [31:0] data);
        @(posedge sysclk);
        reg_raddr <= addr;
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    // Park read address on board status so bit 0 shows DAC busy
    task automatic watch_board();
        @(posedge sysclk);
        reg_raddr <= reg_addr(0, OFF_BOARD);
        @(negedge sysclk);
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge sysclk);
        while (reg_rdata[0] !== level && n < limit) begin
            @(negedge sysclk);
            n++;
        end
        assert (n < limit) else begin
            $display("%s: DAC busy did not go to %0b within %0d cycles",
                     cur_test, level, limit);
            test_errs++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Frame capture on both chains at each rising dac_sclk
    // ------------------------------------------------------------------------
    task automatic capture_transfer();
        logic [23:0] sh [2];
        logic        prev_sclk;
        logic        prev_csn;
        logic [1:0]  prev_mosi;
        int          bits;
        int          n;
        cap_count = 0;
        bits      = 0;
        n         = 0;
        prev_sclk = 1'b0;
        prev_csn  = 1'b1;
        prev_mosi = 2'b00;
        sh[0]     = '0;
        sh[1]     = '0;
        wait_busy(1'b1, BUSY_LIMIT);
        while (reg_rdata[0] === 1'b1 && n < XFER_LIMIT) begin
            if (!dac_csn[0] && dac_sclk && !prev_sclk) begin   // Rising sclk
                // Data set up while sclk low
                check_value("mosi held over sclk rise", {30'd0, prev_mosi}, {30'd0, dac_mosi});
                sh[0] = {sh[0][22:0], dac_mosi[0]};
                sh[1] = {sh[1][22:0], dac_mosi[1]};
                bits++;
            end
            if (!prev_csn && dac_csn[0]) begin                 // End of frame
                check_value($sformatf("bits in frame %0d", cap_count), 32'd24, 32'(bits));
                if (cap_count < 4) begin
                    cap_frame[0][cap_count] = sh[0];
                    cap_frame[1][cap_count] = sh[1];
                end
                cap_count++;
                bits = 0;
            end
            prev_sclk = dac_sclk;
            prev_csn  = dac_csn[0];
            prev_mosi = dac_mosi;
            @(negedge sysclk);
            n++;
        end
        assert (n < XFER_LIMIT) else begin
            $display("%s: DAC transfer did not finish within %0d cycles",
                     cur_test, XFER_LIMIT);
            test_errs++;
        end
    endtask

    // Chain c, frame k carries channel c*4 + k + 1
    task automatic check_frames();
        logic [23:0] exp;
        check_value("frame count", 32'd4, 32'(cap_count));
        for (int c = 0; c < 2; c++) begin
            for (int k = 0; k < 4; k++) begin
                exp = {OPC_WRITE_UPDATE, 4'(k), exp_snap[c*4 + k]};
                check_value($sformatf("chain %0d frame %0d", c, k), {8'd0, exp},
                            {8'd0, cap_frame[c][k]});
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic test_reset_state();
        logic [31:0] rd;
        start_test("reset_state");
        for (int ch = 1; ch <= 8; ch++) begin
            read_reg(reg_addr(ch, OFF_CMD), rd);
            check_value($sformatf("cmd ch%0d", ch), 32'd0, rd);
            read_reg(reg_addr(ch, OFF_STATUS), rd);
            check_value($sformatf("status ch%0d", ch), 32'd0, rd);
        end
        read_reg(reg_addr(0, OFF_BOARD), rd);
        check_value("board status", 32'd0, rd);
        check_value("dac_csn", 32'd3, {30'd0, dac_csn});
        check_value("dac_sclk", 32'd0, {31'd0, dac_sclk});
        check_value("wdog_clear", 32'd0, {31'd0, wdog_clear});
        end_test();
    endtask

    task automatic test_cmd_readback();
        logic [31:0] rd;
        int          low_cnt;
        start_test("cmd_readback");
        low_cnt = 0;
        for (int ch = 1; ch <= 8; ch++) begin
            write_cmd(ch, $urandom, 1'b0);
            read_reg(reg_addr(ch, OFF_CMD), rd);   // One cycle after the write
            check_value($sformatf("cmd ch%0d", ch), {16'd0, model_cmd[ch-1]}, rd);
        end
        repeat (200) begin
            @(negedge sysclk);
            if (dac_csn != 2'b11) low_cnt++;
        end
        check_value("csn low cycles", 32'd0, 32'(low_cnt));
        write_reg(reg_addr(0, OFF_CMD), $urandom, 1'b0);   // Board channel
        write_reg(reg_addr(9, OFF_CMD), $urandom, 1'b0);   // Past last motor
        write_reg(16'h1000 | reg_addr(2, OFF_CMD), $urandom, 1'b0);   // Other space
        for (int ch = 1; ch <= 8; ch++) begin
            read_reg(reg_addr(ch, OFF_CMD), rd);
            check_value($sformatf("kept ch%0d", ch), {16'd0, model_cmd[ch-1]}, rd);
        end
        end_test();
    endtask

    task automatic test_dac_update();
        start_test("dac_update");
        watch_board();
        fork
            capture_transfer();
            write_cmd(4, $urandom, 1'b1);   // Block write triggers update
        join
        exp_snap = model_cmd;
        check_frames();
        end_test();
    endtask

    task automatic test_back_pressure();
        int busy_cnt;
        start_test("back_pressure");
        busy_cnt = 0;
        watch_board();
        fork
            capture_transfer();
            begin
                write_cmd(2, $urandom, 1'b1);
                exp_snap = model_cmd;   // Values at first start
                wait_busy(1'b1, BUSY_LIMIT);
                for (int ch = 1; ch <= 8; ch++) begin
                    write_cmd(ch, $urandom, ch == 8);   // Retrigger while busy
                end
            end
        join
        check_frames();
        exp_snap = model_cmd;
        capture_transfer();   // Pending request runs after busy falls
        check_frames();
        repeat (20) begin
            @(negedge sysclk);
            if (reg_rdata[0]) busy_cnt++;
        end
        check_value("extra busy cycles", 32'd0, 32'(busy_cnt));
        end_test();
    endtask

    task automatic test_watchdog();
        logic [31:0] rd;
        start_test("watchdog");
        write_reg(reg_addr(3, OFF_STATUS), 32'h3, 1'b0);   // Mask plus enable
        check_value("wdog_clear on enable", 32'd1, {31'd0, wen_clear});
        read_reg(reg_addr(3, OFF_STATUS), rd);
        check_value("status enabled", 32'h1, rd);
        @(posedge sysclk);
        wdog_timeout <= 1'b1;
        @(posedge sysclk);
        for (int ch = 1; ch <= 8; ch++) begin
            read_reg(reg_addr(ch, OFF_STATUS), rd);
            check_value($sformatf("status ch%0d timed out", ch), 32'h2, rd);
        end
        read_reg(reg_addr(0, OFF_BOARD), rd);
        check_value("board wdog bit", 32'h2, rd);
        @(posedge sysclk);
        wdog_timeout <= 1'b0;
        write_reg(reg_addr(3, OFF_STATUS), 32'h3, 1'b0);
        check_value("wdog_clear on re-enable", 32'd1, {31'd0, wen_clear});
        read_reg(reg_addr(3, OFF_STATUS), rd);
        check_value("status re-enabled", 32'h1, rd);
        read_reg(reg_addr(5, OFF_STATUS), rd);   // Untouched channel keeps flag
        check_value("status ch5 still safe", 32'h2, rd);
        write_reg(reg_addr(3, OFF_STATUS), 32'h2, 1'b0);   // Masked disable
        check_value("wdog_clear on disable", 32'd0, {31'd0, wen_clear});
        read_reg(reg_addr(0, OFF_BOARD), rd);
        check_value("board status idle", 32'd0, rd);
        end_test();
    endtask

    initial begin
        seed_val     = $urandom(32'hff00_885a);
        rst_n        = 1'b0;
        reg_raddr    = '0;
        reg_waddr    = '0;
        reg_wdata    = '0;
        reg_wen      = 1'b0;
        blk_wen      = 1'b0;
        wdog_timeout = 1'b0;
        wen_clear    = 1'b0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 8; i++) begin
            model_cmd[i] = '0;
        end
        repeat (8) @(posedge sysclk);
        rst_n <= 1'b1;
        test_reset_state();
        test_cmd_readback();
        test_dac_update();
        test_back_pressure();
        test_watchdog();
        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed,
                 total_errs);
        if (total_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* design/dqla_top.sv */
`timescale 1ns/1ps
`include "dqla_macros.svh"

module dqla_top import dqla_pkg::*; (
    input  logic                       sysclk,
    input  logic                       rst_n,
    input  logic [15:0]                reg_raddr,
    input  logic [15:0]                reg_waddr,
    input  logic [31:0]                reg_wdata,
    input  logic                       reg_wen,
    input  logic                       blk_wen,
    input  logic                       wdog_timeout,
    output logic [31:0]                reg_rdata,
    output logic                       wdog_clear,
    output logic                       dac_sclk,
    output logic [`NUM_DAC_CHAINS-1:0] dac_mosi,   // Chain 1 in bit 1
    output logic [`NUM_DAC_CHAINS-1:0] dac_csn
);

    logic [`NUM_MOTORS-1:0] chan_sel;
    logic                   cmd_wr;
    logic                   status_wr;
    logic                   dac_start;
    logic                   dac_busy;
    cur_cmd_t               cur_cmd [`NUM_MOTORS];   // Index 0 is channel 1
    logic [`NUM_MOTORS-1:0] amp_enable;
    logic [`NUM_MOTORS-1:0] safety_disable;

    // ------------------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------------------
    reg_write_decode u_decode (
        .sysclk(sysclk), .rst_n(rst_n), .reg_wen(reg_wen), .blk_wen(blk_wen),
        .dac_busy(dac_busy), .reg_waddr(reg_waddr), .chan_sel(chan_sel),
        .cmd_wr(cmd_wr), .status_wr(status_wr), .dac_start(dac_start)
    );

    // Motor channels
    motor_channel_bank u_bank (
        .sysclk(sysclk), .rst_n(rst_n), .cmd_wr(cmd_wr), .status_wr(status_wr),
        .wdog_timeout(wdog_timeout), .chan_sel(chan_sel), .reg_wdata(reg_wdata),
        .cur_cmd(cur_cmd), .amp_enable(amp_enable), .safety_disable(safety_disable),
        .wdog_clear(wdog_clear)
    );

    // ------------------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------------------
    dac_serializer u_dac (
        .sysclk(sysclk), .rst_n(rst_n), .dac_start(dac_start), .cur_cmd(cur_cmd),
        .dac_busy(dac_busy), .dac_sclk(dac_sclk), .dac_mosi(dac_mosi), .dac_csn(dac_csn)
    );

    reg_read_mux u_rmux (
        .reg_raddr(reg_raddr), .cur_cmd(cur_cmd), .amp_enable(amp_enable),
        .safety_disable(safety_disable), .dac_busy(dac_busy),
        .wdog_timeout(wdog_timeout), .reg_rdata(reg_rdata)
    );

endmodule

/* design/reg_read_mux.sv */
`timescale 1ns/1ps
`include "dqla_macros.svh"

module reg_read_mux import dqla_pkg::*; (
    input  logic [15:0]            reg_raddr,
    input  cur_cmd_t               cur_cmd [`NUM_MOTORS],
    input  logic [`NUM_MOTORS-1:0] amp_enable,
    input  logic [`NUM_MOTORS-1:0] safety_disable,
    input  logic                   dac_busy,
    input  logic                   wdog_timeout,
    output logic [31:0]            reg_rdata
);

    logic [3:0]  rspace;
    logic [3:0]  rchan;
    reg_offset_e roff;
    logic [2:0]  ridx;   // Channel 1-8 as array index

    assign rspace = reg_raddr[`SPACE_HI:`SPACE_LO];
    assign rchan  = reg_raddr[`CHAN_HI:`CHAN_LO];
    assign roff   = reg_offset_e'(reg_raddr[`OFF_HI:`OFF_LO]);
    assign ridx   = 3'(rchan - 4'd1);

    always_comb begin
        reg_rdata = 32'd0;   // Unmapped reads return zero
        if (rspace == `ADDR_MAIN) begin
            if (rchan == 4'd0) begin
                // Board registers
                if (roff == OFF_BOARD_STATUS) begin
                    reg_rdata[`BRD_BUSY_BIT] = dac_busy;
                    reg_rdata[`BRD_WDOG_BIT] = wdog_timeout;
                end
            end else if (rchan <= `NUM_MOTORS) begin
                case (roff)
                    OFF_DAC_CTRL:     reg_rdata = {16'd0, cur_cmd[ridx]};
                    OFF_MOTOR_STATUS: begin
                        reg_rdata[`STAT_AMP_EN_BIT] = amp_enable[ridx];
                        reg_rdata[`STAT_SAFETY_BIT] = safety_disable[ridx];
                    end
                    default: reg_rdata = 32'd0;
                endcase
            end
        end
    end

endmodule

/* dac/dac_serializer.sv */
`timescale 1ns/1ps
`include "dqla_macros.svh"

module dac_serializer import dqla_pkg::*; (
    input  logic                       sysclk,
    input  logic                       rst_n,
    input  logic                       dac_start,
    input  cur_cmd_t                   cur_cmd [`NUM_MOTORS],
    output logic                       dac_busy,
    output logic                       dac_sclk,
    output logic [`NUM_DAC_CHAINS-1:0] dac_mosi,
    output logic [`NUM_DAC_CHAINS-1:0] dac_csn
);

    localparam int BIT_W   = $clog2(`DAC_FRAME_BITS);
    localparam int FRAME_W = $clog2(`CHANS_PER_DAC);
    localparam int ADDR_W  = `DAC_ADDR_BITS;

    dac_state_e                 state;
    logic [BIT_W-1:0]           bit_cnt;     // Bit within frame
    logic [FRAME_W-1:0]         frame_cnt;   // DAC index within chain
    cur_cmd_t                   cmd_hold [`NUM_MOTORS];
    logic [`DAC_FRAME_BITS-1:0] shreg [`NUM_DAC_CHAINS];
    logic                       last_bit;
    logic                       last_frame;

    assign last_bit   = (bit_cnt == BIT_W'(`DAC_FRAME_BITS - 1));
    assign last_frame = (frame_cnt == FRAME_W'(`CHANS_PER_DAC - 1));

    // MSB first on each chain
    always_comb begin
        for (int c = 0; c < `NUM_DAC_CHAINS; c++) begin
            dac_mosi[c] = shreg[c][`DAC_FRAME_BITS-1];
        end
    end

    // Snapshot of all commands at transfer start
    always_ff @(posedge sysclk) begin
        if (state == DAC_IDLE && dac_start) begin
            cmd_hold <= cur_cmd;
        end
    end

    // ------------------------------------------------------------------------
    // Frame sequencer, shared by both chains
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= DAC_IDLE;
            bit_cnt   <= '0;
            frame_cnt <= '0;
            dac_busy  <= 1'b0;
            dac_sclk  <= 1'b0;
            dac_csn   <= '1;
            for (int c = 0; c < `NUM_DAC_CHAINS; c++) begin
                shreg[c] <= '0;
            end
        end else begin
            case (state)
                DAC_IDLE: begin
                    if (dac_start) begin
                        dac_busy  <= 1'b1;
                        frame_cnt <= '0;
                        state     <= DAC_LOAD;
                    end
                end
                DAC_LOAD: begin
                    // Chain c sends channel c*4 + frame_cnt
                    for (int c = 0; c < `NUM_DAC_CHAINS; c++) begin
                        shreg[c] <= {DAC_WRITE_UPDATE, ADDR_W'(frame_cnt),
                                     cmd_hold[c * `CHANS_PER_DAC + int'(frame_cnt)]};
                    end
                    bit_cnt  <= '0;
                    dac_sclk <= 1'b0;
                    dac_csn  <= '0;
                    state    <= DAC_SHIFT;
                end
                DAC_SHIFT: begin
                    dac_sclk <= ~dac_sclk;             // Two sysclk per bit
                    if (dac_sclk) begin                // Falling edge next
                        if (last_bit) begin
                            dac_csn <= '1;
                            state   <= DAC_GAP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            for (int c = 0; c < `NUM_DAC_CHAINS; c++) begin
                                shreg[c] <= {shreg[c][`DAC_FRAME_BITS-2:0], 1'b0};
                            end
                        end
                    end
                end
                DAC_GAP: begin
                    if (last_frame) begin
                        dac_busy <= 1'b0;   // All four DACs written
                        state    <= DAC_IDLE;
                    end else begin
                        frame_cnt <= frame_cnt + 1'b1;
                        state     <= DAC_LOAD;
                    end
                end
                default: state <= DAC_IDLE;
            endcase
        end
    end

    // Chains stay in lock step
    a_csn_match: assert property (@(posedge sysclk) disable iff (!rst_n)
        dac_csn[0] == dac_csn[1]);

    // Chip select only inside a transfer
    a_csn_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
        (dac_csn != '1) |-> dac_busy);

endmodule

/* motor_bank/motor_channel_bank.sv */
`timescale 1ns/1ps
`include "dqla_macros.svh"

module motor_channel_bank import dqla_pkg::*; (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  logic                   cmd_wr,
    input  logic                   status_wr,
    input  logic                   wdog_timeout,
    input  logic [`NUM_MOTORS-1:0] chan_sel,
    input  logic [31:0]            reg_wdata,
    output cur_cmd_t               cur_cmd [`NUM_MOTORS],
    output logic [`NUM_MOTORS-1:0] amp_enable,
    output logic [`NUM_MOTORS-1:0] safety_disable,
    output logic                   wdog_clear
);

    logic en_mask;   // Enable field valid
    logic en_val;    // Requested enable

    assign en_mask = reg_wdata[`AMP_EN_MASK_BIT];
    assign en_val  = reg_wdata[`AMP_EN_BIT];

    // Any enable request clears the watchdog flag
    assign wdog_clear = status_wr && en_mask && en_val;

    // ------------------------------------------------------------------------
    // Commanded current
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_MOTORS; i++) begin
                cur_cmd[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `NUM_MOTORS; i++) begin
                if (cmd_wr && chan_sel[i]) begin
                    cur_cmd[i] <= reg_wdata[15:0];   // Low half only
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Amplifier enable and safety disable
    // ------------------------------------------------------------------------
    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            amp_enable     <= '0;
            safety_disable <= '0;
        end else begin
            for (int i = 0; i < `NUM_MOTORS; i++) begin
                if (wdog_timeout) begin
                    amp_enable[i]     <= 1'b0;   // Watchdog wins over host
                    safety_disable[i] <= 1'b1;
                end else if (status_wr && chan_sel[i] && en_mask) begin
                    amp_enable[i] <= en_val;
                    if (en_val) begin
                        safety_disable[i] <= 1'b0;   // Re-enable acknowledges fault
                    end
                end
            end
        end
    end

    // Timeout must drop every amplifier by the next cycle
    a_wdog_off: assert property (@(posedge sysclk) disable iff (!rst_n)
        wdog_timeout |=> (amp_enable == '0));

endmodule

/* design/reg_write_decode.sv */
`timescale 1ns/1ps
`include "dqla_macros.svh"

module reg_write_decode import dqla_pkg::*; (
    input  logic                   sysclk,
    input  logic                   rst_n,
    input  logic                   reg_wen,
    input  logic                   blk_wen,
    input  logic                   dac_busy,
    input  logic [15:0]            reg_waddr,
    output logic [`NUM_MOTORS-1:0] chan_sel,
    output logic                   cmd_wr,
    output logic                   status_wr,
    output logic                   dac_start
);

    logic [3:0]  wspace;
    logic [3:0]  wchan;
    reg_offset_e woff;
    logic        chan_ok;   // Main space, channel 1-8
    logic        dac_req;   // Pending DAC update
    logic        launch;

    // ------------------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------------------
    assign wspace  = reg_waddr[`SPACE_HI:`SPACE_LO];
    assign wchan   = reg_waddr[`CHAN_HI:`CHAN_LO];
    assign woff    = reg_offset_e'(reg_waddr[`OFF_HI:`OFF_LO]);
    assign chan_ok = (wspace == `ADDR_MAIN) && (wchan != 4'd0) && (wchan <= `NUM_MOTORS);

    // One-hot channel select, bit 0 is channel 1
    always_comb begin
        for (int i = 0; i < `NUM_MOTORS; i++) begin
            chan_sel[i] = chan_ok && (wchan == 4'(i + 1));
        end
    end

    assign cmd_wr    = reg_wen && chan_ok && (woff == OFF_DAC_CTRL);
    assign status_wr = reg_wen && chan_ok && (woff == OFF_MOTOR_STATUS);

    // ------------------------------------------------------------------------
    // DAC update request
    // ------------------------------------------------------------------------
    // Hold off while serializer busy or start still in flight
    assign launch = dac_req && !dac_busy && !dac_start;

    always_ff @(posedge sysclk or negedge rst_n) begin
        if (!rst_n) begin
            dac_req   <= 1'b0;
            dac_start <= 1'b0;
        end else begin
            if (cmd_wr) begin
                dac_req <= blk_wen;        // Last write of a block triggers update
            end else if (launch) begin
                dac_req <= 1'b0;
            end
            dac_start <= launch;           // One-cycle pulse
        end
    end

    // Serializer never sees a start mid-transfer
    a_no_start_busy: assert property (@(posedge sysclk) disable iff (!rst_n)
        !(dac_start && dac_busy));

endmodule

/* common/dqla_pkg.sv */
package dqla_pkg;

    // Per-channel register offsets (addr[3:0])
    typedef enum logic [3:0] {
        OFF_BOARD_STATUS = 4'd0,   // Channel 0 only
        OFF_DAC_CTRL     = 4'd1,   // Commanded current
        OFF_MOTOR_STATUS = 4'd12   // Enable and safety flags
    } reg_offset_e;

    // DAC serializer FSM
    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_LOAD,    // Build next frame
        DAC_SHIFT,   // Clock out bits
        DAC_GAP      // CSn high between frames
    } dac_state_e;

    // LTC2604 command nibble
    typedef enum logic [3:0] {
        DAC_WRITE_INPUT  = 4'b0000,
        DAC_UPDATE       = 4'b0001,
        DAC_WRITE_UPDATE = 4'b0011,  // Write and update in one frame
        DAC_POWER_DOWN   = 4'b0100,
        DAC_NOP          = 4'b1111
    } dac_cmd_e;

    // Commanded motor current
    typedef logic [15:0] cur_cmd_t;

endpackage

/* common/dqla_macros.svh */
`ifndef DQLA_MACROS_SVH
`define DQLA_MACROS_SVH

// ------------------------------------------------------------------------
// Host address fields
// ------------------------------------------------------------------------
`define ADDR_MAIN        4'h0  // Main register space in addr[15:12]
`define SPACE_HI         15
`define SPACE_LO         12
`define CHAN_HI          7     // Channel field
`define CHAN_LO          4
`define OFF_HI           3     // Offset within channel
`define OFF_LO           0

// Motor channels and DAC chains
`define NUM_MOTORS       8
`define CHANS_PER_DAC    4     // Channels 1-4 on chain 0, 5-8 on chain 1
`define NUM_DAC_CHAINS   2

// DAC frame layout: opcode, address, data
`define DAC_FRAME_BITS   24
`define DAC_ADDR_BITS    4

// Write data bits for the motor status register
`define AMP_EN_BIT       0     // Enable value
`define AMP_EN_MASK_BIT  1     // Enable value is meaningful

// Read-back bit positions
`define STAT_AMP_EN_BIT  0
`define STAT_SAFETY_BIT  1
`define BRD_BUSY_BIT     0
`define BRD_WDOG_BIT     1

`endif
